//--- files.f
+incdir+logic
logic/priv_pkg.sv
logic/priv_mode_fsm.sv
logic/priv_csr_regs.sv
logic/cycle_counter.sv
logic/csr_read_forward.sv
logic/priv_csr_top.sv
sim/priv_csr_asserts.sv
sim/priv_csr_tb.sv

//--- Makefile
# Verilator build and run for the privilege CSR slice
VERILATOR ?= verilator
TOP       ?= priv_csr_tb
FILE_LIST ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(filter-out +incdir+%,$(shell cat $(FILE_LIST))) logic/priv_settings.svh
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILE_LIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILE_LIST)

run: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@! grep -q "TESTBENCH FAILED" $(LOG)
	@grep -q "TESTBENCH PASSED" $(LOG) || (echo "TESTBENCH FAILED"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- sim/priv_csr_tb.sv
// ==========================================================================
// testbench for the privilege and status CSR slice
// seeded random traps, xRETs, CSR writes and reads against a cycle model
// ==========================================================================
`include "priv_settings.svh"

module priv_csr_tb
  import priv_pkg::*;
();

  localparam logic [31:0] MSTATUS_WR_MASK =
      (32'h1 << `MSTATUS_SIE_BIT)  | (32'h1 << `MSTATUS_MIE_BIT) |
      (32'h1 << `MSTATUS_SPIE_BIT) | (32'h1 << `MSTATUS_MPIE_BIT) |
      (32'h1 << `MSTATUS_SPP_BIT)  | (32'h3 << `MSTATUS_MPP_LSB) |
      (32'h1 << `MSTATUS_SUM_BIT)  | (32'h1 << `MSTATUS_MXR_BIT);

  logic        clk;
  logic        reset_n;
  ex_stage_t   ex_in;
  mem_stage_t  mem_in;
  logic        exception_in;
  trap_req_t   trap_in;
  logic        mret_flush_in;
  logic        sret_flush_in;
  csr_wr_t     wr_in;
  priv_e       current_priv;
  priv_e       effective_priv;
  logic [31:0] csr_rdata;
  logic [31:0] mstatus_word;

  // reference model state
  logic [1:0]  m_priv;
  logic [31:0] m_ms;
  logic [31:0] m_deleg;
  logic [31:0] m_cycle;
  logic        m_mret_pend;
  logic        m_sret_pend;
  integer      seed;

  priv_csr_top UUT (
    .clk            (clk),
    .reset_n        (reset_n),
    .ex             (ex_in),
    .mem            (mem_in),
    .exception      (exception_in),
    .trap           (trap_in),
    .mret_flush     (mret_flush_in),
    .sret_flush     (sret_flush_in),
    .csr_wr         (wr_in),
    .current_priv   (current_priv),
    .effective_priv (effective_priv),
    .csr_rdata      (csr_rdata),
    .mstatus_word   (mstatus_word)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // ==========================================================================
  // model helpers
  // ==========================================================================
  function automatic int rand_below(input int n);
    int r;
    r = $random(seed);
    return (r & 32'h7fff_ffff) % n;
  endfunction

  function automatic logic [31:0] after_mret(input logic [31:0] ms);
    logic [31:0] r;
    r = ms;
    r[`MSTATUS_MIE_BIT]      = ms[`MSTATUS_MPIE_BIT];
    r[`MSTATUS_MPIE_BIT]     = 1'b1;
    r[`MSTATUS_MPP_LSB +: 2] = 2'b00;
    return r;
  endfunction

  function automatic logic [31:0] after_sret(input logic [31:0] ms);
    logic [31:0] r;
    r = ms;
    r[`MSTATUS_SIE_BIT]  = ms[`MSTATUS_SPIE_BIT];
    r[`MSTATUS_SPIE_BIT] = 1'b1;
    r[`MSTATUS_SPP_BIT]  = 1'b0;
    return r;
  endfunction

  // 2 = MRET in flight, 1 = SRET in flight, 0 = none
  function automatic int xret_in_flight();
    if ((mem_in.valid && mem_in.is_mret && !exception_in) || m_mret_pend) return 2;
    if ((mem_in.valid && mem_in.is_sret && !exception_in) || m_sret_pend) return 1;
    return 0;
  endfunction

  function automatic logic [1:0] expected_priv();
    case (xret_in_flight())
      2:       return m_ms[`MSTATUS_MPP_LSB +: 2];
      1:       return m_ms[`MSTATUS_SPP_BIT] ? 2'b01 : 2'b00;
      default: return m_priv;
    endcase
  endfunction

  function automatic logic [31:0] expected_read(input logic [11:0] addr);
    logic [31:0] view;
    case (xret_in_flight())
      2:       view = after_mret(m_ms);
      1:       view = after_sret(m_ms);
      default: view = m_ms;
    endcase
    case (addr)
      `CSR_MSTATUS: return view;
      `CSR_SSTATUS: return view & `SSTATUS_MASK;
      `CSR_MEDELEG: return m_deleg;
      `CSR_MCYCLE:  return m_cycle;
      default:      return 32'h0;
    endcase
  endfunction

  task automatic update_model();
    logic [31:0] ms;
    logic [31:0] wmask;
    logic [1:0]  target;
    target = (m_priv != 2'b11 && m_deleg[trap_in.cause]) ? 2'b01 : 2'b11;
    ms     = m_ms;
    if (wr_in.strobe) begin
      case (wr_in.addr)
        `CSR_MSTATUS: begin
          wmask = MSTATUS_WR_MASK;
          if (wr_in.data[`MSTATUS_MPP_LSB +: 2] == 2'b10) begin
            wmask = wmask & ~(32'h3 << `MSTATUS_MPP_LSB);  // reserved MPP, old value stays
          end
          ms = (ms & ~wmask) | (wr_in.data & wmask);
        end
        `CSR_SSTATUS: ms = (ms & ~`SSTATUS_MASK) | (wr_in.data & `SSTATUS_MASK);
        `CSR_MEDELEG: m_deleg = wr_in.data;
        default: ;
      endcase
    end
    if (wr_in.strobe && wr_in.addr == `CSR_MCYCLE) begin
      m_cycle = wr_in.data;
    end else begin
      m_cycle = m_cycle + 32'd1;
    end
    if (trap_in.strobe) begin
      if (target == 2'b11) begin
        ms[`MSTATUS_MPP_LSB +: 2] = m_priv;
        ms[`MSTATUS_MPIE_BIT]     = ms[`MSTATUS_MIE_BIT];
        ms[`MSTATUS_MIE_BIT]      = 1'b0;
      end else begin
        ms[`MSTATUS_SPP_BIT]  = m_priv[0];
        ms[`MSTATUS_SPIE_BIT] = ms[`MSTATUS_SIE_BIT];
        ms[`MSTATUS_SIE_BIT]  = 1'b0;
      end
      m_priv = target;
    end else if (mret_flush_in) begin
      m_priv = m_ms[`MSTATUS_MPP_LSB +: 2];  // privilege from the old MPP
      ms     = after_mret(ms);
    end else if (sret_flush_in) begin
      m_priv = m_ms[`MSTATUS_SPP_BIT] ? 2'b01 : 2'b00;
      ms     = after_sret(ms);
    end
    if (trap_in.strobe || mret_flush_in) begin
      m_mret_pend = 1'b0;
    end else if (mem_in.valid && mem_in.is_mret && !exception_in) begin
      m_mret_pend = 1'b1;
    end
    if (trap_in.strobe || sret_flush_in) begin
      m_sret_pend = 1'b0;
    end else if (mem_in.valid && mem_in.is_sret && !exception_in) begin
      m_sret_pend = 1'b1;
    end
    m_ms = ms;
  endtask

  // ==========================================================================
  // checks and cycle stepping
  // ==========================================================================
  task automatic fail_run(input string why);
    $display("%s", why);
    $display("TESTBENCH FAILED");
    $fatal(1, "stopped at first failure");
  endtask

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      fail_run($sformatf("ERROR at time %0t: %s is %h, expected %h", $time, what, got, exp));
    end
  endtask

  task automatic clear_inputs();
    ex_in         = '0;
    mem_in        = '0;
    exception_in  = 1'b0;
    trap_in       = '0;
    mret_flush_in = 1'b0;
    sret_flush_in = 1'b0;
    wr_in         = '0;
  endtask

  // check mid-cycle, update the model on the edge, drive again 2 units later
  task automatic run_cycle();
    #8;
    check_value("current_priv", {30'd0, current_priv}, {30'd0, m_priv});
    check_value("effective_priv", {30'd0, effective_priv}, {30'd0, expected_priv()});
    check_value("mstatus_word", mstatus_word, m_ms);
    if (ex_in.valid && ex_in.is_csr) begin
      check_value("csr_rdata", csr_rdata, expected_read(ex_in.csr_addr));
    end
    @(posedge clk);
    update_model();
    #2;
    clear_inputs();
  endtask

  // ==========================================================================
  // stimulus
  // ==========================================================================
  function automatic logic [11:0] random_csr_addr();
    case (rand_below(4))
      0:       return `CSR_MSTATUS;
      1:       return `CSR_SSTATUS;
      2:       return `CSR_MEDELEG;
      default: return `CSR_MCYCLE;
    endcase
  endfunction

  task automatic set_read(input logic [11:0] addr);
    ex_in.valid    = 1'b1;
    ex_in.is_csr   = 1'b1;
    ex_in.csr_addr = addr;
  endtask

  // MPP may come out as the reserved encoding too
  task automatic set_write();
    wr_in.strobe = 1'b1;
    wr_in.addr   = random_csr_addr();
    wr_in.data   = $random(seed);
  endtask

  task automatic do_trap();
    trap_in.strobe = 1'b1;
    trap_in.cause  = 5'(rand_below(32));
    if (rand_below(4) == 0) set_write();  // write under the trap
    if (rand_below(2) == 0) set_read(random_csr_addr());
    run_cycle();
  endtask

  task automatic do_xret();
    logic is_m;
    logic with_exc;
    int   gap;
    is_m           = rand_below(2) == 0;
    with_exc       = rand_below(5) == 0;
    gap            = 1 + rand_below(3);
    mem_in.valid   = 1'b1;
    mem_in.is_mret = is_m;
    mem_in.is_sret = !is_m;
    exception_in   = with_exc;
    set_read(rand_below(2) == 0 ? `CSR_MSTATUS : `CSR_SSTATUS);
    run_cycle();
    if (with_exc) return;  // nothing in flight
    for (int k = 1; k <= gap; k++) begin
      if (k == gap) begin
        mret_flush_in = is_m;
        sret_flush_in = !is_m;
      end
      if (rand_below(3) != 0) set_read(rand_below(2) == 0 ? `CSR_MSTATUS : `CSR_SSTATUS);
      run_cycle();
    end
    set_read(`CSR_MSTATUS);  // committed value
    run_cycle();
  endtask

  task automatic do_write();
    logic [11:0] addr;
    set_write();
    addr = wr_in.addr;
    run_cycle();
    for (int k = 0; k < ((addr == `CSR_MCYCLE) ? 3 : 1); k++) begin
      set_read(addr);
      run_cycle();
    end
  endtask

  initial begin
    int waited;
    seed        = 32'hc35a_db11;
    reset_n     = 1'b0;
    clear_inputs();
    m_priv      = 2'b11;
    m_ms        = 32'h0;
    m_deleg     = 32'h0;
    m_cycle     = 32'h0;
    m_mret_pend = 1'b0;
    m_sret_pend = 1'b0;
    repeat (4) @(posedge clk);
    #2;
    reset_n = 1'b1;
    waited  = 0;
    while (current_priv !== PRIV_M || mstatus_word !== 32'h0) begin
      if (waited == 10) fail_run("timeout: the DUT never showed its reset state");
      @(posedge clk);
      #2;
      m_cycle = m_cycle + 32'd1;
      waited++;
    end
    for (int n = 0; n < 500; n++) begin
      case (rand_below(4))
        0:       do_trap();
        1:       do_xret();
        2:       do_write();
        default: begin
          set_read(random_csr_addr());
          run_cycle();
        end
      endcase
    end
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

//--- sim/priv_csr_asserts.sv
// ==========================================================================
// concurrent checks on the privilege FSM and the pending xRET flags
// ==========================================================================
module priv_csr_asserts
  import priv_pkg::*;
(
  input logic       clk,
  input logic       reset_n,
  input mem_stage_t mem,
  input logic       exception,
  input logic       mret_pending,
  input logic       sret_pending,
  input priv_e      current_priv,
  input priv_e      effective_priv
);

  logic xret_in_flight;

  assign xret_in_flight = (mem.valid && (mem.is_mret || mem.is_sret) && !exception) ||
                          mret_pending || sret_pending;

  pending_clear_after_reset: assert property (
    @(posedge clk) !reset_n |=> (!mret_pending && !sret_pending)
  ) else $error("pending xRET flag set right after reset");

  // encoding 2 is reserved
  no_reserved_priv: assert property (
    @(posedge clk) disable iff (!reset_n) (2'(current_priv) != 2'b10)
  ) else $error("privilege register holds the reserved encoding");

  effective_follows_current: assert property (
    @(posedge clk) disable iff (!reset_n) !xret_in_flight |-> effective_priv == current_priv
  ) else $error("effective privilege differs with no xRET in flight");

endmodule

// pending flags reach the FSM from csr_read_forward
bind priv_mode_fsm priv_csr_asserts u_priv_csr_asserts (
  .clk            (clk),
  .reset_n        (reset_n),
  .mem            (mem),
  .exception      (exception),
  .mret_pending   (mret_pending),
  .sret_pending   (sret_pending),
  .current_priv   (current_priv),
  .effective_priv (effective_priv)
);

//--- logic/priv_csr_top.sv
// ==========================================================================
// privilege and status CSR slice, top level
// ==========================================================================
`include "priv_settings.svh"

module priv_csr_top
  import priv_pkg::*;
(
  input  logic             clk,
  input  logic             reset_n,
  input  ex_stage_t        ex,
  input  mem_stage_t       mem,
  input  logic             exception,
  input  trap_req_t        trap,
  input  logic             mret_flush,
  input  logic             sret_flush,
  input  csr_wr_t          csr_wr,
  output priv_e            current_priv,
  output priv_e            effective_priv,
  output logic [`XLEN-1:0] csr_rdata,
  output logic [`XLEN-1:0] mstatus_word
);

  mstatus_t         mstatus;
  logic [`XLEN-1:0] medeleg;
  logic [`XLEN-1:0] mcycle;
  priv_e            trap_priv;
  logic             mret_pending;
  logic             sret_pending;

  assign mstatus_word = mstatus.word;

  priv_mode_fsm u_priv_mode_fsm (
    .clk            (clk),
    .reset_n        (reset_n),
    .trap           (trap),
    .mret_flush     (mret_flush),
    .sret_flush     (sret_flush),
    .mstatus        (mstatus),
    .medeleg        (medeleg),
    .mem            (mem),
    .exception      (exception),
    .mret_pending   (mret_pending),
    .sret_pending   (sret_pending),
    .current_priv   (current_priv),
    .effective_priv (effective_priv),
    .trap_priv      (trap_priv)
  );

  priv_csr_regs u_priv_csr_regs (
    .clk          (clk),
    .reset_n      (reset_n),
    .csr_wr       (csr_wr),
    .trap         (trap),
    .trap_priv    (trap_priv),
    .current_priv (current_priv),
    .mret_flush   (mret_flush),
    .sret_flush   (sret_flush),
    .mstatus      (mstatus),
    .medeleg      (medeleg)
  );

  cycle_counter u_cycle_counter (
    .clk     (clk),
    .reset_n (reset_n),
    .csr_wr  (csr_wr),
    .mcycle  (mcycle)
  );

  csr_read_forward u_csr_read_forward (
    .clk          (clk),
    .reset_n      (reset_n),
    .ex           (ex),
    .mem          (mem),
    .exception    (exception),
    .trap_strobe  (trap.strobe),
    .mret_flush   (mret_flush),
    .sret_flush   (sret_flush),
    .mstatus      (mstatus),
    .medeleg      (medeleg),
    .mcycle       (mcycle),
    .mret_pending (mret_pending),
    .sret_pending (sret_pending),
    .csr_rdata    (csr_rdata)
  );

endmodule

//--- logic/csr_read_forward.sv
// ==========================================================================
// CSR read mux for the EX stage, pending MRET and SRET flags
// post-return mstatus forwarding while an xRET has not committed
// ==========================================================================
`include "priv_settings.svh"

module csr_read_forward
  import priv_pkg::*;
(
  input  logic             clk,
  input  logic             reset_n,
  input  ex_stage_t        ex,
  input  mem_stage_t       mem,
  input  logic             exception,
  input  logic             trap_strobe,
  input  logic             mret_flush,
  input  logic             sret_flush,
  input  mstatus_t         mstatus,
  input  logic [`XLEN-1:0] medeleg,
  input  logic [`XLEN-1:0] mcycle,
  output logic             mret_pending,
  output logic             sret_pending,
  output logic [`XLEN-1:0] csr_rdata
);

  logic     mem_mret;
  logic     mem_sret;
  logic     fwd_mret;
  logic     fwd_sret;
  logic     ex_read;
  mstatus_t ms_ret;    // mstatus after the in-flight return
  mstatus_t ms_view;   // what EX actually sees

  assign mem_mret = mem.valid && mem.is_mret && !exception;
  assign mem_sret = mem.valid && mem.is_sret && !exception;

  // ==========================================================================
  // pending flags, held from MEM until the flush commits
  // ==========================================================================
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      mret_pending <= 1'b0;
      sret_pending <= 1'b0;
    end else begin
      if (trap_strobe || mret_flush) begin
        mret_pending <= 1'b0;
      end else if (mem_mret) begin
        mret_pending <= 1'b1;
      end

      if (trap_strobe || sret_flush) begin
        sret_pending <= 1'b0;
      end else if (mem_sret) begin
        sret_pending <= 1'b1;
      end
    end
  end

  assign fwd_mret = mem_mret || mret_pending;
  assign fwd_sret = mem_sret || sret_pending;
  assign ex_read  = ex.valid && ex.is_csr;

  // MRET wins if both are somehow in flight
  always_comb begin
    if (fwd_mret) begin
      ms_ret = mret_update(mstatus);
    end else if (fwd_sret) begin
      ms_ret = sret_update(mstatus);
    end else begin
      ms_ret = mstatus;
    end
  end

  assign ms_view = ex_read ? ms_ret : mstatus;

  // ==========================================================================
  // read mux
  // ==========================================================================
  always_comb begin
    case (ex.csr_addr)
      `CSR_MSTATUS: csr_rdata = ms_view.word;
      `CSR_SSTATUS: csr_rdata = ms_view.word & `SSTATUS_MASK;
      `CSR_MEDELEG: csr_rdata = medeleg;
      `CSR_MCYCLE:  csr_rdata = mcycle;
      default:      csr_rdata = '0;  // unimplemented reads as zero
    endcase
  end

endmodule

//--- logic/cycle_counter.sv
// ==========================================================================
// free-running mcycle counter, loadable through the CSR write port
// ==========================================================================
`include "priv_settings.svh"

module cycle_counter
  import priv_pkg::*;
(
  input  logic             clk,
  input  logic             reset_n,
  input  csr_wr_t          csr_wr,
  output logic [`XLEN-1:0] mcycle
);

  logic load;

  assign load = csr_wr.strobe && (csr_wr.addr == `CSR_MCYCLE);

  // wraps at 2^32, counting resumes from the written value
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      mcycle <= '0;
    end else if (load) begin
      mcycle <= csr_wr.data;
    end else begin
      mcycle <= mcycle + 1'b1;
    end
  end

endmodule

//--- logic/priv_csr_regs.sv
// ==========================================================================
// mstatus and medeleg storage
// CSR writes first, then trap entry or xRET field updates on top
// ==========================================================================
`include "priv_settings.svh"

module priv_csr_regs
  import priv_pkg::*;
(
  input  logic             clk,
  input  logic             reset_n,
  input  csr_wr_t          csr_wr,
  input  trap_req_t        trap,
  input  priv_e            trap_priv,
  input  priv_e            current_priv,
  input  logic             mret_flush,
  input  logic             sret_flush,
  output mstatus_t         mstatus,
  output logic [`XLEN-1:0] medeleg
);

  mstatus_t         ms_wr;       // write data seen through the field view
  mstatus_t         ms_next;
  logic [`XLEN-1:0] medeleg_next;

  assign ms_wr.word = csr_wr.data;

  // ==========================================================================
  // next state
  // ==========================================================================
  always_comb begin
    ms_next      = mstatus;
    medeleg_next = medeleg;

    if (csr_wr.strobe) begin
      case (csr_wr.addr)
        `CSR_MSTATUS: begin
          // only the implemented fields are writable
          ms_next.f.sie  = ms_wr.f.sie;
          ms_next.f.mie  = ms_wr.f.mie;
          ms_next.f.spie = ms_wr.f.spie;
          ms_next.f.mpie = ms_wr.f.mpie;
          ms_next.f.spp  = ms_wr.f.spp;
          ms_next.f.sum  = ms_wr.f.sum;
          ms_next.f.mxr  = ms_wr.f.mxr;
          if (ms_wr.f.mpp != 2'b10) begin  // reserved encoding keeps old MPP
            ms_next.f.mpp = ms_wr.f.mpp;
          end
        end
        `CSR_SSTATUS: begin
          ms_next.word = (mstatus.word & ~`SSTATUS_MASK) |
                         (csr_wr.data & `SSTATUS_MASK);
        end
        `CSR_MEDELEG: medeleg_next = csr_wr.data;
        default: ;  // other addresses live elsewhere
      endcase
    end

    if (trap.strobe) begin
      if (trap_priv == PRIV_M) begin
        ms_next.f.mpp  = current_priv;
        ms_next.f.mpie = ms_next.f.mie;
        ms_next.f.mie  = 1'b0;
      end else begin
        ms_next.f.spp  = current_priv[0];
        ms_next.f.spie = ms_next.f.sie;
        ms_next.f.sie  = 1'b0;
      end
    end else if (mret_flush) begin
      ms_next = mret_update(ms_next);
    end else if (sret_flush) begin
      ms_next = sret_update(ms_next);
    end
  end

  // ==========================================================================
  // registers
  // ==========================================================================
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      mstatus.word <= '0;
      medeleg      <= '0;
    end else begin
      mstatus <= ms_next;
      medeleg <= medeleg_next;
    end
  end

endmodule

//--- logic/priv_mode_fsm.sv
// ==========================================================================
// privilege mode register with trap, MRET and SRET transitions
// trap target selection from medeleg, effective privilege for EX
// ==========================================================================
`include "priv_settings.svh"

module priv_mode_fsm
  import priv_pkg::*;
(
  input  logic             clk,
  input  logic             reset_n,
  input  trap_req_t        trap,
  input  logic             mret_flush,
  input  logic             sret_flush,
  input  mstatus_t         mstatus,
  input  logic [`XLEN-1:0] medeleg,
  input  mem_stage_t       mem,
  input  logic             exception,
  input  logic             mret_pending,
  input  logic             sret_pending,
  output priv_e            current_priv,
  output priv_e            effective_priv,
  output priv_e            trap_priv
);

  priv_e mret_priv;
  priv_e sret_priv;
  logic  fwd_mret;
  logic  fwd_sret;

  // delegation only applies below machine mode
  assign trap_priv = (current_priv != PRIV_M && medeleg[trap.cause]) ? PRIV_S : PRIV_M;

  assign mret_priv = priv_e'(mstatus.f.mpp);
  assign sret_priv = mstatus.f.spp ? PRIV_S : PRIV_U;

  // ==========================================================================
  // privilege register
  // ==========================================================================
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      current_priv <= priv_e'(`PRIV_RESET);
    end else if (trap.strobe) begin   // trap beats both returns
      current_priv <= trap_priv;
    end else if (mret_flush) begin
      current_priv <= mret_priv;
    end else if (sret_flush) begin
      current_priv <= sret_priv;
    end
  end

  // ==========================================================================
  // privilege seen by EX while an xRET is in flight
  // ==========================================================================
  assign fwd_mret = (mem.valid && mem.is_mret && !exception) || mret_pending;
  assign fwd_sret = (mem.valid && mem.is_sret && !exception) || sret_pending;

  always_comb begin
    if (fwd_mret) begin
      effective_priv = mret_priv;
    end else if (fwd_sret) begin
      effective_priv = sret_priv;
    end else begin
      effective_priv = current_priv;
    end
  end

endmodule

//--- logic/priv_pkg.sv
// ==========================================================================
// privilege enum, pipeline stage descriptors, trap and CSR write structs
// mstatus union and the shared xRET field update functions
// ==========================================================================
`include "priv_settings.svh"

package priv_pkg;

  typedef enum logic [1:0] {
    PRIV_U = 2'b00,
    PRIV_S = 2'b01,
    PRIV_M = 2'b11
  } priv_e;

  // standard RV32 mstatus layout, reserved bits kept as pads
  typedef struct packed {
    logic [11:0] pad_31_20;
    logic        mxr;        // 19
    logic        sum;        // 18
    logic [4:0]  pad_17_13;
    logic [1:0]  mpp;        // 12:11
    logic [1:0]  pad_10_9;
    logic        spp;        // 8
    logic        mpie;       // 7
    logic        pad_6;
    logic        spie;       // 5
    logic        pad_4;
    logic        mie;        // 3
    logic        pad_2;
    logic        sie;        // 1
    logic        pad_0;
  } mstatus_fields_t;

  typedef union packed {
    logic [`XLEN-1:0] word;  // CSR port view
    mstatus_fields_t  f;     // update logic view
  } mstatus_t;

  typedef struct packed {
    logic        valid;
    logic        is_csr;
    logic [11:0] csr_addr;
  } ex_stage_t;

  typedef struct packed {
    logic valid;
    logic is_mret;
    logic is_sret;
  } mem_stage_t;

  typedef struct packed {
    logic       strobe;
    logic [4:0] cause;
  } trap_req_t;

  typedef struct packed {
    logic             strobe;
    logic [11:0]      addr;
    logic [`XLEN-1:0] data;
  } csr_wr_t;

  // MRET field update, MIE <- MPIE, MPIE <- 1, MPP <- U
  function automatic mstatus_t mret_update(mstatus_t ms);
    mstatus_t r;
    r        = ms;
    r.f.mie  = ms.f.mpie;
    r.f.mpie = 1'b1;
    r.f.mpp  = PRIV_U;
    return r;
  endfunction

  // SRET field update, SIE <- SPIE, SPIE <- 1, SPP <- U
  function automatic mstatus_t sret_update(mstatus_t ms);
    mstatus_t r;
    r        = ms;
    r.f.sie  = ms.f.spie;
    r.f.spie = 1'b1;
    r.f.spp  = 1'b0;
    return r;
  endfunction

endpackage

//--- logic/priv_settings.svh
// ==========================================================================
// register width, CSR addresses and mstatus field positions
// reset privilege and the sstatus field mask
// ==========================================================================
`ifndef PRIV_SETTINGS_SVH
`define PRIV_SETTINGS_SVH

`define XLEN 32

// CSR addresses
`define CSR_MSTATUS 12'h300
`define CSR_SSTATUS 12'h100
`define CSR_MEDELEG 12'h302
`define CSR_MCYCLE  12'hB00

// mstatus field positions
`define MSTATUS_SIE_BIT  1
`define MSTATUS_MIE_BIT  3
`define MSTATUS_SPIE_BIT 5
`define MSTATUS_MPIE_BIT 7
`define MSTATUS_SPP_BIT  8
`define MSTATUS_MPP_LSB  11
`define MSTATUS_SUM_BIT  18
`define MSTATUS_MXR_BIT  19

// SIE, SPIE, SPP, SUM and MXR
`define SSTATUS_MASK 32'h000C_0122

`define PRIV_RESET 2'b11  // machine mode

`endif
